// ==== verilog/ddr3_wr_pkg.sv ====
`default_nettype none

package ddr3_wr_pkg;

	// width of one frame word as it comes out of the ADC FIFO
	localparam int WORD_W = 128;
	// byte-level memory address seen on app_addr
	localparam int ADDR_W = 26;
	// address counter in units of 8-word lines
	localparam int LINE_W = 23;
	// number of data words following a header
	localparam int BURST_W = 21;

	// frame delimiters in bits 127:126
	localparam logic [1:0] HDR_TAG = 2'b01;
	localparam logic [1:0] FTR_TAG = 2'b10;

	// header layout, msb first
	// tag 127:126, burst count 84:64, start line 57:35
	typedef struct packed {
		logic [1:0]         tag;
		logic [125:85]      rsvd_hi;
		logic [BURST_W-1:0] burst_count;
		logic [63:58]       rsvd_gap;
		logic [LINE_W-1:0]  start_line;
		logic [34:0]        rsvd_lo;
	} hdr_fields_t;

	// one frame word, decoded as header/footer or passed raw as data
	typedef union packed {
		logic [WORD_W-1:0] raw;
		hdr_fields_t       hdr;
	} frame_word_t;

	// native app_cmd codes
	typedef enum logic [2:0] {
		APP_CMD_WR = 3'b000,
		APP_CMD_RD = 3'b001
	} app_cmd_t;

endpackage

`default_nettype wire

// ==== verilog/wr_addr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// write command request from the frame controller to the arbiter
interface wr_addr_if;
	import ddr3_wr_pkg::*;

	// one more write command wanted
	logic              wr_request;
	// address of the next write, line counter times 8
	logic [ADDR_W-1:0] wr_addr;
	// frame in progress, writes win the arbiter
	logic              wr_mode;
	// pulse when the memory takes the write command
	logic              wr_addr_ack;

	modport ctrl (output wr_request, output wr_addr, output wr_mode, input wr_addr_ack);
	modport arb (input wr_request, input wr_addr, input wr_mode, output wr_addr_ack);

endinterface

`default_nettype wire

// ==== verilog/sync_fwft_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fwft_fifo #(
	parameter int WIDTH = 128,
	parameter int DEPTH = 16
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_dat,
	output logic             full,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_dat,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// word storage
	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// push into a full FIFO and pop from an empty one are dropped
	assign do_push = wr_en & ~full;
	assign do_pop  = rd_en & ~empty;

	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	// head word shows without a read strobe
	assign rd_dat = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wr_dat;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap at DEPTH, so any depth works
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ddr3_wr_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_wr_control (
	input  logic                          clk,
	input  logic                          reset,
	// frame FIFO head, first-word fall-through
	input  ddr3_wr_pkg::frame_word_t      frame_dat,
	input  logic                          frame_empty,
	output logic                          frame_rd_en,
	// memory write data channel
	output logic                          app_wdf_wren,
	input  logic                          app_wdf_rdy,
	output logic [ddr3_wr_pkg::WORD_W-1:0] app_wdf_data,
	output logic                          app_wdf_end,
	// write command requests to the arbiter
	wr_addr_if.ctrl                       addr,
	// fill-header FIFO
	output logic [ddr3_wr_pkg::WORD_W-1:0] hdr_wr_dat,
	output logic                          hdr_wr_en,
	output logic                          sync_err
);

	import ddr3_wr_pkg::*;

	// one-hot state bit positions
	localparam int IDLE        = 0;
	localparam int TST_HDR_TAG = 1;
	localparam int INIT        = 2;
	localparam int WRITE       = 3;
	localparam int TST_FTR_TAG = 4;
	localparam int SYNC_ERR    = 5;
	localparam int DONE        = 6;

	logic [6:0]         state;
	logic [6:0]         next_state;
	logic [WORD_W-1:0]  hdr_latch;
	logic [BURST_W-1:0] data_cnt;
	logic [BURST_W-1:0] cmd_cnt;
	logic [LINE_W-1:0]  addr_cnt;
	logic               beat_done;

	// a beat moves when both sides agree
	assign beat_done = app_wdf_wren & app_wdf_rdy;

	// copy of the header, kept for the readout client
	always_ff @(posedge clk) begin
		if (state[INIT])
			hdr_latch <= frame_dat.raw;
	end

	// data burst counter, counts accepted beats down
	always_ff @(posedge clk) begin
		if (reset)
			data_cnt <= '0;
		else if (state[INIT])
			data_cnt <= frame_dat.hdr.burst_count;
		else if (beat_done)
			data_cnt <= data_cnt - 1'b1;
	end

	// command counter runs apart from the data count,
	// commands and data beats are accepted independently
	always_ff @(posedge clk) begin
		if (reset)
			cmd_cnt <= '0;
		else if (state[INIT])
			cmd_cnt <= frame_dat.hdr.burst_count;
		else if (addr.wr_addr_ack)
			cmd_cnt <= cmd_cnt - 1'b1;
	end

	// line address, one step per accepted write command
	always_ff @(posedge clk) begin
		if (reset)
			addr_cnt <= '0;
		else if (state[INIT])
			addr_cnt <= frame_dat.hdr.start_line;
		else if (addr.wr_addr_ack)
			addr_cnt <= addr_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= 7'(1) << IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = '0;
		case (1'b1)
			// wait for the first word of a frame
			state[IDLE]:
				if (frame_empty)
					next_state[IDLE] = 1'b1;
				else
					next_state[TST_HDR_TAG] = 1'b1;
			// header is at the head, check its tag
			state[TST_HDR_TAG]:
				if (frame_dat.hdr.tag == HDR_TAG)
					next_state[INIT] = 1'b1;
				else
					next_state[SYNC_ERR] = 1'b1;
			// counters load and header pops here
			// an empty burst skips straight to the footer
			state[INIT]:
				if (frame_dat.hdr.burst_count == '0)
					next_state[TST_FTR_TAG] = 1'b1;
				else
					next_state[WRITE] = 1'b1;
			// stay until every beat and every command is taken
			state[WRITE]:
				if (data_cnt == '0 && cmd_cnt == '0)
					next_state[TST_FTR_TAG] = 1'b1;
				else
					next_state[WRITE] = 1'b1;
			// footer may not have arrived yet
			state[TST_FTR_TAG]:
				if (frame_empty)
					next_state[TST_FTR_TAG] = 1'b1;
				else if (frame_dat.hdr.tag == FTR_TAG)
					next_state[DONE] = 1'b1;
				else
					next_state[SYNC_ERR] = 1'b1;
			// lost framing, only reset gets out
			state[SYNC_ERR]:
				next_state[SYNC_ERR] = 1'b1;
			state[DONE]:
				next_state[IDLE] = 1'b1;
			default:
				next_state[IDLE] = 1'b1;
		endcase
	end

	// data words go out raw straight from the FIFO head
	assign app_wdf_wren = state[WRITE] & ~frame_empty & (data_cnt != '0);
	assign app_wdf_data = frame_dat.raw;
	assign app_wdf_end  = app_wdf_wren;

	// pop the header in INIT, each accepted beat in WRITE, the footer in DONE
	assign frame_rd_en = state[INIT] | state[DONE] | beat_done;

	assign addr.wr_request = state[WRITE] & (cmd_cnt != '0);
	assign addr.wr_addr    = {addr_cnt, 3'b000};
	// held through the error state too, keeps reads off the bus
	assign addr.wr_mode    = ~state[IDLE];

	assign hdr_wr_dat = hdr_latch;
	assign hdr_wr_en  = state[DONE];
	assign sync_err   = state[SYNC_ERR];

endmodule

`default_nettype wire

// ==== verilog/ddr3_addr_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_addr_control (
	input  logic                          clk,
	input  logic                          reset,
	// write requests from the frame controller
	wr_addr_if.arb                        addr,
	// external read requests
	input  logic                          rd_request,
	input  logic [ddr3_wr_pkg::ADDR_W-1:0] rd_addr,
	output logic                          rd_addr_ack,
	// memory command channel
	output logic                          app_en,
	output ddr3_wr_pkg::app_cmd_t         app_cmd,
	output logic [ddr3_wr_pkg::ADDR_W-1:0] app_addr,
	input  logic                          app_rdy
);

	import ddr3_wr_pkg::*;

	// holding register for the command on the bus
	logic              cmd_valid;
	// tag bit, high when the held command is a write
	logic              cmd_is_wr;
	logic [ADDR_W-1:0] cmd_addr;
	logic              accept;
	logic              take_wr;
	logic              take_rd;

	assign accept = cmd_valid & app_rdy;

	// register takes a new command only while it is empty,
	// so the requester has already seen the ack of the last one
	// and updated its counters and address
	assign take_wr = ~cmd_valid & addr.wr_mode & addr.wr_request;
	assign take_rd = ~cmd_valid & ~addr.wr_mode & rd_request;

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_valid <= 1'b0;
			cmd_is_wr <= 1'b0;
		end else if (take_wr) begin
			cmd_valid <= 1'b1;
			cmd_is_wr <= 1'b1;
		end else if (take_rd) begin
			cmd_valid <= 1'b1;
			cmd_is_wr <= 1'b0;
		end else if (accept) begin
			cmd_valid <= 1'b0;
		end
	end

	// address of the held command, written on a load
	always_ff @(posedge clk) begin
		if (take_wr)
			cmd_addr <= addr.wr_addr;
		else if (take_rd)
			cmd_addr <= rd_addr;
	end

	assign app_en   = cmd_valid;
	assign app_cmd  = cmd_is_wr ? APP_CMD_WR : APP_CMD_RD;
	assign app_addr = cmd_addr;

	// ack goes back to whoever owns the held command
	assign addr.wr_addr_ack = accept & cmd_is_wr;
	assign rd_addr_ack      = accept & ~cmd_is_wr;

endmodule

`default_nettype wire

// ==== verilog/ddr3_wr_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_wr_path #(
	parameter int FRAME_FIFO_DEPTH = 16,
	parameter int HDR_FIFO_DEPTH   = 4
) (
	input  logic                          clk,
	input  logic                          reset,
	// ADC capture stream
	input  logic                          adc_wr_en,
	input  logic [ddr3_wr_pkg::WORD_W-1:0] adc_dat,
	output logic                          adc_full,
	// memory write data channel
	output logic                          app_wdf_wren,
	output logic [ddr3_wr_pkg::WORD_W-1:0] app_wdf_data,
	output logic                          app_wdf_end,
	input  logic                          app_wdf_rdy,
	// memory command channel
	output logic                          app_en,
	output ddr3_wr_pkg::app_cmd_t         app_cmd,
	output logic [ddr3_wr_pkg::ADDR_W-1:0] app_addr,
	input  logic                          app_rdy,
	// read client
	input  logic                          rd_request,
	input  logic [ddr3_wr_pkg::ADDR_W-1:0] rd_addr,
	output logic                          rd_addr_ack,
	// fill-header readout
	input  logic                          hdr_rd_en,
	output logic [ddr3_wr_pkg::WORD_W-1:0] hdr_dat,
	output logic                          hdr_empty,
	output logic                          sync_err
);

	import ddr3_wr_pkg::*;

	logic [WORD_W-1:0] frame_dat;
	logic              frame_empty;
	logic              frame_rd_en;
	logic [WORD_W-1:0] hdr_wr_dat;
	logic              hdr_wr_en;

	wr_addr_if wr_addr_bus ();

	// ADC frames waiting for the controller
	sync_fwft_fifo #(.WIDTH(WORD_W), .DEPTH(FRAME_FIFO_DEPTH)) frame_fifo_inst (
		.clk(clk), .reset(reset),
		.wr_en(adc_wr_en), .wr_dat(adc_dat), .full(adc_full),
		.rd_en(frame_rd_en), .rd_dat(frame_dat), .empty(frame_empty)
	);

	ddr3_wr_control wr_control_inst (
		.clk(clk), .reset(reset),
		.frame_dat(frame_dat), .frame_empty(frame_empty), .frame_rd_en(frame_rd_en),
		.app_wdf_wren(app_wdf_wren), .app_wdf_rdy(app_wdf_rdy),
		.app_wdf_data(app_wdf_data), .app_wdf_end(app_wdf_end),
		.addr(wr_addr_bus.ctrl),
		.hdr_wr_dat(hdr_wr_dat), .hdr_wr_en(hdr_wr_en), .sync_err(sync_err)
	);

	ddr3_addr_control addr_control_inst (
		.clk(clk), .reset(reset),
		.addr(wr_addr_bus.arb),
		.rd_request(rd_request), .rd_addr(rd_addr), .rd_addr_ack(rd_addr_ack),
		.app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr), .app_rdy(app_rdy)
	);

	// headers of finished frames for the readout client
	sync_fwft_fifo #(.WIDTH(WORD_W), .DEPTH(HDR_FIFO_DEPTH)) hdr_fifo_inst (
		.clk(clk), .reset(reset),
		.wr_en(hdr_wr_en), .wr_dat(hdr_wr_dat), .full(),
		.rd_en(hdr_rd_en), .rd_dat(hdr_dat), .empty(hdr_empty)
	);

endmodule

`default_nettype wire

// ==== dv/ddr3_wr_path_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_wr_path_tb;
	import ddr3_wr_pkg::*;

	// frame sizes used below, header and footer included in the word count
	localparam int TOTAL_WORDS = 41;
	localparam int TOTAL_BURST = 25;
	localparam int NUM_FRAMES  = 8;
	// ready is forced high after 3 low cycles, at most 4 cycles a beat and 5 a command
	localparam int CYCLE_LIMIT = 2 * TOTAL_WORDS + 9 * TOTAL_BURST + 16 * NUM_FRAMES + 200;

	logic              clk = 1'b0;
	logic              reset;
	logic              adc_wr_en;
	logic [WORD_W-1:0] adc_dat;
	logic              adc_full;
	logic              app_wdf_wren;
	logic [WORD_W-1:0] app_wdf_data;
	logic              app_wdf_end;
	logic              app_wdf_rdy;
	logic              app_en;
	app_cmd_t          app_cmd;
	logic [ADDR_W-1:0] app_addr;
	logic              app_rdy;
	logic              rd_request;
	logic [ADDR_W-1:0] rd_addr;
	logic              rd_addr_ack;
	logic              hdr_rd_en;
	logic [WORD_W-1:0] hdr_dat;
	logic              hdr_empty;
	logic              sync_err;

	// scoreboard, filled before the words enter the DUT
	logic [WORD_W-1:0] exp_data[$];
	logic [ADDR_W-1:0] exp_addr[$];
	logic [ADDR_W-1:0] exp_rd[$];
	logic [WORD_W-1:0] exp_hdr[$];
	logic              in_frame = 1'b0;
	logic              bp_on = 1'b0;
	logic [15:0]       stim_lfsr = 16'd11144;
	logic [15:0]       rdy_lfsr = 16'd11144;
	int                wdf_low = 0;
	int                cmd_low = 0;
	int                errors = 0;
	int                checks = 0;
	int                tests_run = 0;
	int                test_errs = 0;
	int                rd_acks = 0;
	int                cycles = 0;
	// last cycle's stall state and held values
	logic              wdf_stalled = 1'b0;
	logic              cmd_stalled = 1'b0;
	logic [WORD_W-1:0] held_data;
	logic [ADDR_W-1:0] held_addr;
	app_cmd_t          held_cmd;

	ddr3_wr_path ddr3_wr_path_inst (.*);

	always #2 clk = ~clk;

	// Galois LFSR, one step per bit taken
	function automatic logic [WORD_W-1:0] lfsr_bits(inout logic [15:0] state, input int n);
		logic [WORD_W-1:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			state = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
			v = {v[WORD_W-2:0], state[0]};
		end
		return v;
	endfunction

	task automatic note_mismatch(input string sig, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] exp);
		$display("mismatch at %0t ns: %s got %h expected %h", $time, sig, got, exp);
		errors++;
	endtask

	task automatic note_failure(input string what);
		$display("error at %0t ns: %s", $time, what);
		errors++;
	endtask

	// memory ready model, random with a bounded low streak
	always @(negedge clk) begin
		app_wdf_rdy = !bp_on || wdf_low >= 3 || lfsr_bits(rdy_lfsr, 1) != '0;
		app_rdy     = !bp_on || cmd_low >= 3 || lfsr_bits(rdy_lfsr, 1) != '0;
		wdf_low     = app_wdf_rdy ? 0 : wdf_low + 1;
		cmd_low     = app_rdy ? 0 : cmd_low + 1;
	end

	// transfer checks at the DUT ports
	always @(posedge clk) begin
		if (reset) begin
			wdf_stalled = 1'b0;
			cmd_stalled = 1'b0;
		end else begin
			// stalled beat and command must not move
			if (wdf_stalled) begin
				assert (app_wdf_wren && app_wdf_data == held_data) checks++;
				else note_mismatch("app_wdf_data held", app_wdf_data, held_data);
			end
			if (cmd_stalled) begin
				assert (app_en && app_addr == held_addr && app_cmd == held_cmd) checks++;
				else note_mismatch("app_addr held", app_addr, held_addr);
			end
			if (app_wdf_wren && app_wdf_rdy) begin
				assert (app_wdf_end) checks++;
				else note_mismatch("app_wdf_end", app_wdf_end, 1'b1);
				assert (exp_data.size() > 0)
				else note_failure("write beat with no data word pending");
				if (exp_data.size() > 0) begin
					assert (app_wdf_data == exp_data[0]) checks++;
					else note_mismatch("app_wdf_data", app_wdf_data, exp_data[0]);
					void'(exp_data.pop_front());
				end
			end
			if (app_en && app_rdy && app_cmd == APP_CMD_WR) begin
				assert (exp_addr.size() > 0)
				else note_failure("write command with no address pending");
				if (exp_addr.size() > 0) begin
					assert (app_addr == exp_addr[0]) checks++;
					else note_mismatch("app_addr", app_addr, exp_addr[0]);
					void'(exp_addr.pop_front());
				end
			end else if (app_en && app_rdy) begin
				assert (app_cmd == APP_CMD_RD && !in_frame && exp_rd.size() > 0) checks++;
				else note_failure("read command out of place or not requested");
				if (exp_rd.size() > 0) begin
					assert (app_addr == exp_rd[0]) checks++;
					else note_mismatch("app_addr read", app_addr, exp_rd[0]);
					void'(exp_rd.pop_front());
				end
			end
			// ack only for an accepted read
			assert (rd_addr_ack == (app_en && app_rdy && app_cmd == APP_CMD_RD)) checks++;
			else note_mismatch("rd_addr_ack", rd_addr_ack, !rd_addr_ack);
			if (rd_addr_ack)
				rd_acks++;
			wdf_stalled = app_wdf_wren && !app_wdf_rdy;
			cmd_stalled = app_en && !app_rdy;
			held_data   = app_wdf_data;
			held_addr   = app_addr;
			held_cmd    = app_cmd;
		end
	end

	// framing error holds until reset
	sync_err_sticky: assert property (@(posedge clk) disable iff (reset) sync_err |=> sync_err)
		else note_failure("sync_err dropped without a reset");
	// no traffic toward memory once framing is lost
	sync_err_quiet: assert property (@(posedge clk) disable iff (reset)
		sync_err |-> !app_wdf_wren && !app_en)
		else note_failure("memory traffic after sync_err");

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic apply_reset();
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		exp_data.delete();
		exp_addr.delete();
		exp_hdr.delete();
		in_frame = 1'b0;
		assert (!app_wdf_wren && !app_en && !rd_addr_ack && !sync_err && hdr_empty && !adc_full)
			checks++;
		else note_failure("outputs not at their reset values");
	endtask

	// one ADC word, with an occasional idle cycle before it
	task automatic push_word(input logic [WORD_W-1:0] w);
		if (lfsr_bits(stim_lfsr, 2) == '0)
			@(negedge clk);
		while (adc_full)
			@(negedge clk);
		adc_wr_en = 1'b1;
		adc_dat   = w;
		@(negedge clk);
		adc_wr_en = 1'b0;
	endtask

	task automatic send_frame(input int burst, input logic [22:0] line,
			input logic [1:0] htag, input logic [1:0] ftag);
		logic [WORD_W-1:0] words[$];
		logic [WORD_W-1:0] w;
		logic [22:0]       ln;
		w = lfsr_bits(stim_lfsr, WORD_W);
		w[127:126] = htag;
		w[84:64]   = 21'(burst);
		w[57:35]   = line;
		words.push_back(w);
		if (htag == 2'b01 && ftag == 2'b10)
			exp_hdr.push_back(w);
		for (int k = 0; k < burst; k++) begin
			w  = lfsr_bits(stim_lfsr, WORD_W);
			ln = line + 23'(k);
			words.push_back(w);
			// commands may run ahead of data, so queue the whole frame first
			if (htag == 2'b01) begin
				exp_data.push_back(w);
				exp_addr.push_back({ln, 3'b000});
			end
		end
		w = lfsr_bits(stim_lfsr, WORD_W);
		w[127:126] = ftag;
		words.push_back(w);
		in_frame = 1'b1;
		foreach (words[i])
			push_word(words[i]);
	endtask

	// end of frame shows as the header FIFO going non-empty
	task automatic wait_frame_end();
		do @(negedge clk); while (hdr_empty);
		assert (exp_hdr.size() > 0) checks++;
		else note_failure("header written with no frame finished");
		if (exp_hdr.size() > 0) begin
			assert (hdr_dat == exp_hdr[0]) checks++;
			else note_mismatch("hdr_dat", hdr_dat, exp_hdr[0]);
			void'(exp_hdr.pop_front());
		end
		if (exp_hdr.size() == 0)
			in_frame = 1'b0;
		hdr_rd_en = 1'b1;
		@(negedge clk);
		hdr_rd_en = 1'b0;
	endtask

	task automatic issue_read(input logic [ADDR_W-1:0] a);
		rd_request = 1'b1;
		rd_addr    = a;
		exp_rd.push_back(a);
	endtask

	// client drops its request after the ack
	task automatic wait_read_ack();
		int seen;
		seen = rd_acks;
		do @(negedge clk); while (rd_acks == seen);
		rd_request = 1'b0;
	endtask

	task automatic wait_sync_err();
		do @(negedge clk); while (!sync_err);
		repeat (20) begin
			@(negedge clk);
			assert (sync_err && hdr_empty) checks++;
			else note_failure("sync_err fell or a header was written after a framing error");
		end
	endtask

	task automatic check_drained();
		assert (exp_data.size() == 0 && exp_addr.size() == 0 && exp_rd.size() == 0) checks++;
		else note_failure("beats or commands missing at the end of the test");
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		$display("test %0d %s: %s, %0d errors", tests_run, name,
			(errors == test_errs) ? "ok" : "failed", errors - test_errs);
		test_errs = errors;
	endtask

	initial begin
		reset       = 1'b1;
		adc_wr_en   = 1'b0;
		adc_dat     = '0;
		app_wdf_rdy = 1'b1;
		app_rdy     = 1'b1;
		rd_request  = 1'b0;
		rd_addr     = '0;
		hdr_rd_en   = 1'b0;
		apply_reset();

		send_frame(0, 23'(lfsr_bits(stim_lfsr, 23)), 2'b01, 2'b10);
		wait_frame_end();
		check_drained();
		finish_test("empty burst");

		send_frame(1, 23'(lfsr_bits(stim_lfsr, 23)), 2'b01, 2'b10);
		wait_frame_end();
		check_drained();
		finish_test("single beat");

		// from here on the memory stalls at random
		@(posedge clk);
		bp_on = 1'b1;
		@(negedge clk);
		send_frame(6, 23'(lfsr_bits(stim_lfsr, 23)), 2'b01, 2'b10);
		wait_frame_end();
		check_drained();
		finish_test("back-pressure");

		// second frame wraps the line counter
		send_frame(3, 23'(lfsr_bits(stim_lfsr, 23)), 2'b01, 2'b10);
		send_frame(5, 23'h7ffffe, 2'b01, 2'b10);
		wait_frame_end();
		wait_frame_end();
		check_drained();
		finish_test("frame order");

		issue_read(26'h2a55a8);
		wait_read_ack();
		send_frame(6, 23'(lfsr_bits(stim_lfsr, 23)), 2'b01, 2'b10);
		issue_read(26'h1f00c8);
		fork
			wait_frame_end();
			wait_read_ack();
		join
		check_drained();
		finish_test("read arbitration");

		apply_reset();
		send_frame(2, 23'(lfsr_bits(stim_lfsr, 23)), 2'b11, 2'b10);
		wait_sync_err();
		check_drained();
		finish_test("bad header tag");

		apply_reset();
		send_frame(2, 23'(lfsr_bits(stim_lfsr, 23)), 2'b01, 2'b11);
		wait_sync_err();
		check_drained();
		finish_test("bad footer tag");

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/ddr3_wr_pkg.sv
verilog/wr_addr_if.sv
verilog/sync_fwft_fifo.sv
verilog/ddr3_wr_control.sv
verilog/ddr3_addr_control.sv
verilog/ddr3_wr_path.sv
dv/ddr3_wr_path_tb.sv

// ==== Bender.yml ====
package:
  name: ddr3_wr_path

sources:
  - verilog/ddr3_wr_pkg.sv
  - verilog/wr_addr_if.sv
  - verilog/sync_fwft_fifo.sv
  - verilog/ddr3_wr_control.sv
  - verilog/ddr3_addr_control.sv
  - verilog/ddr3_wr_path.sv
  - target: test
    files:
      - dv/ddr3_wr_path_tb.sv
